// ==== Bender.yml ====
package:
  name: msx_cart

export_include_dirs:
  - hw

sources:
  - files:
      - hw/cart_pkg.sv
      - hw/msx_bus_capture.sv
      - hw/sdc_regs.sv
      - hw/cart_bus_responder.sv
      - hw/msx_cart_top.sv
  - target: simulation
    files:
      - bench/msx_cart_assert.sv
      - bench/msx_cart_tb.sv

// ==== bench/cart_patterns.txt ====
# op addr data chk exp (hex), MR: chk 1 wants cd_out == exp, chk 0 wants cd released
# MW/ST: chk is the expected sd op (0 none), exp its sector; IW: chk mapper type, exp scc
MR 7E02 00 0 00000000
MW 7E00 01 0 00000000
MR 7E00 00 1 00000001
MW 7E03 44 0 00000000
MW 7E04 33 0 00000000
MW 7E05 22 0 00000000
MW 7E06 11 0 00000000
MR 7E05 00 1 00000022
MW 7E01 01 1 11223344
MR 7E06 00 1 00000011
MW 7E06 AA 0 00000000
ST 0000 01 0 00000000
MW 7E01 01 0 00000000
MW 7E01 80 0 00000000
ST 0000 00 1 AA223344
MW 7E01 82 2 AA223344
SS 0000 83 0 00000000
MR 7E02 00 1 00000083
SS 0000 02 0 00000000
MR 7E02 00 1 00000002
SS 0000 00 0 00000000
MR 7E40 00 1 000000FF
IW 008F 05 1 00000001
IW 008F 16 2 00000000
IW 008E 08 2 00000000
IW 0090 00 2 00000000
IW 008F 08 3 00000000
IW 008F 00 0 00000000

// ==== bench/msx_cart_assert.sv ====
`default_nettype none

module msx_cart_assert (
    input  wire                   clk108_w,
    input  wire                   ram_enabled_w,
    input  wire cart_pkg::bus_phase_e phase,
    input  wire  [2:0]            msel_n,
    input  wire cart_pkg::sd_cmd_t sd_req,
    input  wire                   sd_req_valid,
    input  wire                   sd_req_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    import cart_pkg::*;

    logic fail_seen = 1'b0;     // sticky once any property fails

    //////////////////////////////////////////////////
    // phase sequencer
    //////////////////////////////////////////////////

    // one step per clock with a wrap after IDLE_WAIT
    phase_step: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        1'b1 |=> phase == bus_phase_e'($past(phase) + 3'd1))
        else begin
            fail_seen = 1'b1;
            $error("bus phase did not advance by one");
        end

    mux_select: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        $onehot0(~msel_n))
        else begin
            fail_seen = 1'b1;
            $error("more than one msel_n line low");
        end

    //////////////////////////////////////////////////
    // sd request channel
    //////////////////////////////////////////////////

    req_stable: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        sd_req_valid && !sd_req_ready |=> $stable(sd_req))
        else begin
            fail_seen = 1'b1;
            $error("sd_req changed while waiting for ready");
        end

    // valid is only dropped by a transfer
    req_held: assert property (@(posedge clk108_w) disable iff (!ram_enabled_w)
        sd_req_valid && !sd_req_ready |=> sd_req_valid)
        else begin
            fail_seen = 1'b1;
            $error("sd_req_valid dropped without a transfer");
        end

endmodule

`default_nettype wire

// ==== bench/msx_cart_tb.sv ====
`default_nettype none

`include "cart_params.svh"

module msx_cart_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cart_pkg::*;

    localparam int MAX_PAT = 64;

    logic                    clk108_w = 1'b0;
    logic                    ram_enabled_w;
    logic [`CART_DATA_W-1:0] mp;
    logic [2:0]              msel_n;
    logic                    rd_n;
    logic                    wr_n;
    logic                    sltsl_n;
    logic [`CART_DATA_W-1:0] cd_in;
    logic [`CART_DATA_W-1:0] cd_out;
    logic                    datadir;
    logic                    busdir_n;
    mapper_type_e            mapper_type;
    logic                    scc_enable;
    sd_cmd_t                 sd_req;
    logic                    sd_req_valid;
    logic                    sd_req_ready;
    logic                    sd_busy;
    logic                    sd_crc_error;
    logic                    sd_timeout_error;
    logic                    sd_enabled;

    logic [15:0]             pat_op [MAX_PAT];
    logic [15:0]             pat_addr [MAX_PAT];
    logic [7:0]              pat_data [MAX_PAT];
    logic [7:0]              pat_chk [MAX_PAT];
    logic [31:0]             pat_exp [MAX_PAT];
    int                      pat_count;
    logic [15:0]             cur_addr;       // transaction the bus model presents
    logic [7:0]              cur_ctrl;
    logic                    stall_hold;
    int                      stall_cnt;
    logic [31:0]             lfsr_state;
    int                      cycle_count;
    int                      cycle_limit;
    sd_cmd_t                 req_q [$];

    msx_cart_top i_msx_cart_top (.*);

    bind msx_cart_top msx_cart_assert i_msx_cart_assert (
        .clk108_w     (clk108_w),
        .ram_enabled_w(ram_enabled_w),
        .phase        (i_msx_bus_capture.phase),
        .msel_n       (msel_n),
        .sd_req       (sd_req),
        .sd_req_valid (sd_req_valid),
        .sd_req_ready (sd_req_ready)
    );

    initial begin
        forever #20 clk108_w = ~clk108_w;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    // galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = 8'h00;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[6:0], lfsr_state[0]};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // msx bus model and sd engine model
    //////////////////////////////////////////////////

    always @(negedge clk108_w) begin
        case (msel_n)
            3'b110:  mp <= cur_addr[7:0];
            3'b101:  mp <= cur_addr[15:8];
            3'b011:  mp <= cur_ctrl;
            default: mp <= 8'hFF;
        endcase
    end

    always @(negedge clk108_w) begin
        if (sd_req_ready) begin
            sd_req_ready = 1'b0;
            stall_cnt = rand_bits(3);   // fresh stall for the next request
        end else if (sd_req_valid && !stall_hold) begin
            if (stall_cnt == 0) begin
                sd_req_ready = 1'b1;
            end else begin
                stall_cnt--;
            end
        end
    end

    always @(posedge clk108_w) begin
        if (sd_req_valid && sd_req_ready) begin
            req_q.push_back(sd_req);
        end
        assert (!i_msx_cart_top.i_msx_cart_assert.fail_seen)
            else report_error("a bound assertion on the bus or sd channel failed");
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_error($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    //////////////////////////////////////////////////
    // pattern file and transactions
    //////////////////////////////////////////////////

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [15:0] op;
        logic [15:0] a;
        logic [7:0]  d;
        logic [7:0]  c;
        logic [31:0] e;
        fd = $fopen("bench/cart_patterns.txt", "r");
        if (fd == 0) begin
            report_error("cannot open bench/cart_patterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;   // blank or comment
            end
            n = $sscanf(line, "%s %h %h %h %h", op, a, d, c, e);
            if (n == 5 && pat_count < MAX_PAT) begin
                pat_op[pat_count]   = op;
                pat_addr[pat_count] = a;
                pat_data[pat_count] = d;
                pat_chk[pat_count]  = c;
                pat_exp[pat_count]  = e;
                pat_count++;
            end
        end
        $fclose(fd);
    endtask

    // three rotations of strobes with the drive checked on every falling edge
    task automatic bus_cycle(input logic io, input logic rd, input logic [15:0] addr,
                             input logic [7:0] data, input logic drive_exp,
                             input logic [7:0] rdata_exp, input string name);
        logic driven;
        driven = 1'b0;
        @(negedge clk108_w);
        cur_addr = addr;
        cur_ctrl = io ? 8'hFD : 8'hFE;      // iorq_n or merq_n low
        cd_in    = rd ? 8'hFF : data;
        repeat (`CART_PHASES) @(negedge clk108_w);
        rd_n    = !rd;
        wr_n    = rd;
        sltsl_n = io;
        repeat (3 * `CART_PHASES) begin
            @(negedge clk108_w);
            if (!datadir && !driven) begin
                driven = 1'b1;
                assert (drive_exp) else report_error($sformatf("%s drove cd unexpectedly", name));
                assert (cd_out == rdata_exp) else report_error(
                    $sformatf("ERR %s expected %02h actual %02h", name, rdata_exp, cd_out));
            end
        end
        assert (driven == drive_exp) else report_error($sformatf("%s never drove cd", name));
        rd_n    = 1'b1;
        wr_n    = 1'b1;
        sltsl_n = 1'b1;
        repeat (`CART_PHASES) @(negedge clk108_w);
    endtask

    task automatic check_request(input logic [7:0] op_exp, input logic [31:0] sector_exp,
                                 input string name);
        sd_cmd_t got;
        while (req_q.size() == 0) begin
            @(negedge clk108_w);
        end
        got = req_q.pop_front();
        assert (got.op == sd_op_e'(op_exp[1:0]) && got.sector == sector_exp) else report_error(
            $sformatf("ERR %s expected op %0d sector %08h actual op %0d sector %08h",
                      name, op_exp, sector_exp, got.op, got.sector));
    endtask

    task automatic run_pattern(input int i);
        string name;
        name = $sformatf("pattern %0d %s %04h", i + 1, pat_op[i], pat_addr[i]);
        case (pat_op[i])
            "MW": begin
                bus_cycle(1'b0, 1'b0, pat_addr[i], pat_data[i], 1'b0, 8'h00, name);
                if (pat_addr[i] == `SDC_ENABLE_ADDR) begin
                    assert (sd_enabled == pat_data[i][0]) else report_error(
                        $sformatf("ERR %s expected enable %0d actual %0d",
                                  name, pat_data[i][0], sd_enabled));
                end
                if (pat_chk[i] != 0) begin
                    check_request(pat_chk[i], pat_exp[i], name);
                end
            end
            "MR": bus_cycle(1'b0, 1'b1, pat_addr[i], 8'h00, pat_chk[i][0], pat_exp[i][7:0], name);
            "IW": begin
                bus_cycle(1'b1, 1'b0, pat_addr[i], pat_data[i], 1'b0, 8'h00, name);
                assert (mapper_type == mapper_type_e'(pat_chk[i][1:0])
                        && scc_enable == pat_exp[i][0]) else report_error(
                    $sformatf("ERR %s expected type %0d scc %0d actual type %0d scc %0d",
                              name, pat_chk[i], pat_exp[i][0], mapper_type, scc_enable));
            end
            "SS": begin
                @(negedge clk108_w);
                sd_busy          = pat_data[i][7];
                sd_timeout_error = pat_data[i][1];
                sd_crc_error     = pat_data[i][0];
            end
            "ST": begin
                @(negedge clk108_w);
                stall_hold = pat_data[i][0];    // 1 keeps ready low
                if (pat_chk[i] != 0) begin
                    check_request(pat_chk[i], pat_exp[i], name);
                end
            end
            default: report_error($sformatf("unknown operation in %s", name));
        endcase
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [2:0] sel_exp;
        ram_enabled_w    = 1'b0;
        mp               = 8'hFF;
        rd_n             = 1'b1;
        wr_n             = 1'b1;
        sltsl_n          = 1'b1;
        cd_in            = 8'hFF;
        sd_req_ready     = 1'b0;
        sd_busy          = 1'b0;
        sd_crc_error     = 1'b0;
        sd_timeout_error = 1'b0;
        cur_addr         = 16'h0000;
        cur_ctrl         = 8'hFF;
        stall_hold       = 1'b0;
        cycle_count      = 0;
        cycle_limit      = 200;
        pat_count        = 0;
        lfsr_state       = 32'h7c2f7e26;
        stall_cnt        = rand_bits(3);

        load_patterns();
        cycle_limit = pat_count * 40 + 200;

        repeat (4) @(negedge clk108_w);
        assert (msel_n == 3'b111 && !sd_req_valid && datadir && busdir_n
                && mapper_type == MAP_KONAMI && !scc_enable && !sd_enabled)
            else report_error("outputs not at their reset values");
        ram_enabled_w = 1'b1;

        // two full rotations with each select held two clocks
        for (int k = 0; k < 2 * `CART_PHASES; k++) begin
            @(negedge clk108_w);
            case ((k / 2) % 4)
                0:       sel_exp = 3'b110;
                1:       sel_exp = 3'b101;
                2:       sel_exp = 3'b011;
                default: sel_exp = 3'b111;
            endcase
            assert (msel_n == sel_exp) else report_error(
                $sformatf("ERR rotation step %0d expected %03b actual %03b", k, sel_exp, msel_n));
            assert (datadir) else report_error("datadir went low while the bus was idle");
        end

        for (int i = 0; i < pat_count; i++) begin
            run_pattern(i);
        end

        repeat (`CART_PHASES) @(negedge clk108_w);
        assert (req_q.size() == 0) else report_error("sd engine saw an extra request");
        assert (busdir_n) else report_error("busdir_n went low");
        assert (!i_msx_cart_top.i_msx_cart_assert.fail_seen)
            else report_error("a bound assertion on the bus or sd channel failed");
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hw
hw/cart_pkg.sv
hw/msx_bus_capture.sv
hw/sdc_regs.sv
hw/cart_bus_responder.sv
hw/msx_cart_top.sv
bench/msx_cart_assert.sv
bench/msx_cart_tb.sv

// ==== hw/cart_bus_responder.sv ====
`default_nettype none

`include "cart_params.svh"

module cart_bus_responder (
    input  wire                      clk108_w,
    input  wire                      ram_enabled_w,
    input  wire cart_pkg::bus_cycle_t cycle,
    input  wire                      cycle_valid,
    input  wire  [`CART_DATA_W-1:0]  data_in,
    input  wire  [`CART_DATA_W-1:0]  sdc_rdata,
    input  wire                      sdc_hit,
    output logic [`CART_DATA_W-1:0]  cd_out,
    output logic                     datadir,
    output logic                     busdir_n,
    output cart_pkg::mapper_type_e   mapper_type,
    output logic                     scc_enable
);

    import cart_pkg::*;

    logic port_wr;

    //////////////////////////////////////////////////
    // mapper type port
    //////////////////////////////////////////////////

    // plain i/o write, not an interrupt ack
    assign port_wr = cycle_valid && !cycle.iorq_n && cycle.m1_n && !cycle.wr_n
                     && (cycle.addr[7:0] == `MAPPER_PORT);

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            mapper_type <= MAP_KONAMI;
            scc_enable  <= 1'b0;
        end else if (port_wr) begin
            case (data_in)
                8'h05: begin
                    mapper_type <= MAP_KONAMI_SCC;
                    scc_enable  <= 1'b1;
                end
                8'h16: begin
                    mapper_type <= MAP_ASCII16;
                    scc_enable  <= 1'b0;
                end
                8'h08: begin
                    mapper_type <= MAP_ASCII8;
                    scc_enable  <= 1'b0;
                end
                default: begin      // anything else falls back to konami
                    mapper_type <= MAP_KONAMI;
                    scc_enable  <= 1'b0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // cartridge data bus
    //////////////////////////////////////////////////

    always_ff @(posedge clk108_w) begin
        if (cycle_valid) begin
            cd_out <= sdc_hit ? sdc_rdata : `CART_IDLE_DATA;
        end
    end

    // drive cd only for a decoded read, let go as soon as rd or sltsl rise
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            datadir <= 1'b1;
        end else if (cycle.rd_n || cycle.sltsl_n) begin
            datadir <= 1'b1;
        end else if (cycle_valid && sdc_hit) begin
            datadir <= 1'b0;        // same edge as cd_out
        end
    end

    // no i/o read port here, so the slot buffer never turns for iorq
    assign busdir_n = 1'b1;

endmodule

`default_nettype wire

// ==== hw/cart_params.svh ====
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

//////////////////////////////////////////////////
// cartridge bus widths
//////////////////////////////////////////////////

`define CART_ADDR_W       16          // z80 address bus
`define CART_DATA_W       8           // cd / mp byte lanes
`define CART_SECTOR_W     32          // sd block address

// mux rotation, two cycles per msel group
`define CART_PHASES       8

//////////////////////////////////////////////////
// sd controller window in the primary slot
//////////////////////////////////////////////////

`define SDC_ENABLE_ADDR   16'h7E00    // bit 0 opens the rest of the window
`define SDC_CMD_ADDR      16'h7E01    // 1 read, 2 write, 80h init
`define SDC_STATUS_ADDR   16'h7E02    // busy / timeout / crc
`define SDC_SADDR_ADDR    16'h7E03    // four bytes, lsb first
`define SDC_END_ADDR      16'h7EFF

// open bus value for anything not backed by a register
`define CART_IDLE_DATA    8'hFF

//////////////////////////////////////////////////
// i/o ports
//////////////////////////////////////////////////

`define MAPPER_PORT       8'h8F       // megaram type select

`endif

// ==== hw/cart_pkg.sv ====
`default_nettype none

`include "cart_params.svh"

package cart_pkg;

    // one entry per clock of the msel rotation
    typedef enum logic [$clog2(`CART_PHASES)-1:0] {
        LOW_SEL,        // msel_n 110, a0-a7 settling
        LOW_SAMPLE,
        HIGH_SEL,       // msel_n 101, a8-a15
        HIGH_SAMPLE,
        CTRL_SEL,       // msel_n 011, merq/iorq/rfsh/m1
        CTRL_SAMPLE,
        IDLE_SEL,       // nothing on mp, cycle is published here
        IDLE_WAIT
    } bus_phase_e;

    // demultiplexed view of one z80 bus cycle, all strobes active low
    typedef struct packed {
        logic [`CART_ADDR_W-1:0] addr;
        logic                    merq_n;
        logic                    iorq_n;
        logic                    m1_n;
        logic                    rfsh_n;
        logic                    rd_n;      // synchronized pin levels
        logic                    wr_n;
        logic                    sltsl_n;
    } bus_cycle_t;

    typedef enum logic [1:0] {
        SD_NONE  = 2'd0,
        SD_READ  = 2'd1,
        SD_WRITE = 2'd2,
        SD_INIT  = 2'd3
    } sd_op_e;

    // request handed to the sd engine
    typedef struct packed {
        sd_op_e                    op;
        logic [`CART_SECTOR_W-1:0] sector;
    } sd_cmd_t;

    // encodings follow the port 8fh convention
    typedef enum logic [1:0] {
        MAP_KONAMI     = 2'd0,
        MAP_KONAMI_SCC = 2'd1,
        MAP_ASCII16    = 2'd2,
        MAP_ASCII8     = 2'd3
    } mapper_type_e;

endpackage

`default_nettype wire

// ==== hw/msx_bus_capture.sv ====
`default_nettype none

`include "cart_params.svh"

module msx_bus_capture (
    input  wire                      clk108_w,
    input  wire                      ram_enabled_w,
    input  wire  [`CART_DATA_W-1:0]  mp,
    input  wire                      rd_n,
    input  wire                      wr_n,
    input  wire                      sltsl_n,
    output logic [2:0]               msel_n,
    output cart_pkg::bus_cycle_t     cycle,
    output logic                     cycle_valid
);

    import cart_pkg::*;

    bus_phase_e             phase;
    bus_phase_e             phase_next;
    logic [2:0]             sel_next;
    logic [7:0]             addr_lo;
    logic [7:0]             addr_hi;
    logic [`CART_ADDR_W-1:0] addr_q;
    logic [3:0]             ctrl_q;         // {m1_n, rfsh_n, iorq_n, merq_n}
    logic [2:0]             strobe_meta;
    logic [2:0]             strobe_sync;    // {rd_n, wr_n, sltsl_n}

    //////////////////////////////////////////////////
    // phase rotation and mux select
    //////////////////////////////////////////////////

    assign phase_next = bus_phase_e'(phase + 3'd1);

    // select for the phase we are about to enter
    always_comb begin
        case (phase_next)
            LOW_SEL, LOW_SAMPLE:   sel_next = 3'b110;
            HIGH_SEL, HIGH_SAMPLE: sel_next = 3'b101;
            CTRL_SEL, CTRL_SAMPLE: sel_next = 3'b011;
            default:               sel_next = 3'b111;
        endcase
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            phase  <= IDLE_WAIT;    // first edge lands on LOW_SEL
            msel_n <= 3'b111;
        end else begin
            phase  <= phase_next;
            msel_n <= sel_next;
        end
    end

    //////////////////////////////////////////////////
    // byte capture off the shared mp pins
    //////////////////////////////////////////////////

    // second cycle of each pair, mux output has settled by then
    always_ff @(posedge clk108_w) begin
        if (phase == LOW_SAMPLE) begin
            addr_lo <= mp;
        end
        if (phase == HIGH_SAMPLE) begin
            addr_hi <= mp;
        end
        if (phase == CTRL_SAMPLE) begin
            addr_q <= {addr_hi, addr_lo};  // published with the control byte
        end
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            ctrl_q <= 4'b1111;              // all inactive
        end else if (phase == CTRL_SAMPLE) begin
            ctrl_q <= {mp[7], mp[5], mp[1], mp[0]};
        end
    end

    // rd/wr/sltsl come straight from the slot, double flop them
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            strobe_meta <= 3'b111;
            strobe_sync <= 3'b111;
        end else begin
            strobe_meta <= {rd_n, wr_n, sltsl_n};
            strobe_sync <= strobe_meta;
        end
    end

    always_comb begin
        cycle.addr    = addr_q;
        cycle.merq_n  = ctrl_q[0];
        cycle.iorq_n  = ctrl_q[1];
        cycle.rfsh_n  = ctrl_q[2];
        cycle.m1_n    = ctrl_q[3];
        cycle.rd_n    = strobe_sync[2];
        cycle.wr_n    = strobe_sync[1];
        cycle.sltsl_n = strobe_sync[0];
    end

    assign cycle_valid = (phase == IDLE_SEL);   // once per rotation

endmodule

`default_nettype wire

// ==== hw/msx_cart_top.sv ====
`default_nettype none

`include "cart_params.svh"

module msx_cart_top (
    input  wire                      clk108_w,
    input  wire                      ram_enabled_w,
    // slot side
    input  wire  [`CART_DATA_W-1:0]  mp,
    output logic [2:0]               msel_n,
    input  wire                      rd_n,
    input  wire                      wr_n,
    input  wire                      sltsl_n,
    input  wire  [`CART_DATA_W-1:0]  cd_in,
    output logic [`CART_DATA_W-1:0]  cd_out,
    output logic                     datadir,
    output logic                     busdir_n,
    output cart_pkg::mapper_type_e   mapper_type,
    output logic                     scc_enable,
    // sd engine side
    output cart_pkg::sd_cmd_t        sd_req,
    output logic                     sd_req_valid,
    input  wire                      sd_req_ready,
    input  wire                      sd_busy,
    input  wire                      sd_crc_error,
    input  wire                      sd_timeout_error,
    output logic                     sd_enabled
);

    import cart_pkg::*;

    bus_cycle_t              cycle;
    logic                    cycle_valid;
    logic [`CART_DATA_W-1:0] sdc_rdata;
    logic                    sdc_hit;

    msx_bus_capture i_msx_bus_capture (
        .clk108_w     (clk108_w),
        .ram_enabled_w(ram_enabled_w),
        .mp           (mp),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .sltsl_n      (sltsl_n),
        .msel_n       (msel_n),
        .cycle        (cycle),
        .cycle_valid  (cycle_valid)
    );

    sdc_regs i_sdc_regs (
        .clk108_w        (clk108_w),
        .ram_enabled_w   (ram_enabled_w),
        .cycle           (cycle),
        .cycle_valid     (cycle_valid),
        .data_in         (cd_in),
        .sd_req_ready    (sd_req_ready),
        .sd_busy         (sd_busy),
        .sd_crc_error    (sd_crc_error),
        .sd_timeout_error(sd_timeout_error),
        .sd_req          (sd_req),
        .sd_req_valid    (sd_req_valid),
        .sdc_rdata       (sdc_rdata),
        .sdc_hit         (sdc_hit),
        .sd_enabled      (sd_enabled)
    );

    cart_bus_responder i_cart_bus_responder (
        .clk108_w     (clk108_w),
        .ram_enabled_w(ram_enabled_w),
        .cycle        (cycle),
        .cycle_valid  (cycle_valid),
        .data_in      (cd_in),
        .sdc_rdata    (sdc_rdata),
        .sdc_hit      (sdc_hit),
        .cd_out       (cd_out),
        .datadir      (datadir),
        .busdir_n     (busdir_n),
        .mapper_type  (mapper_type),
        .scc_enable   (scc_enable)
    );

endmodule

`default_nettype wire

// ==== hw/sdc_regs.sv ====
`default_nettype none

`include "cart_params.svh"

module sdc_regs (
    input  wire                      clk108_w,
    input  wire                      ram_enabled_w,
    input  wire cart_pkg::bus_cycle_t cycle,
    input  wire                      cycle_valid,
    input  wire  [`CART_DATA_W-1:0]  data_in,
    input  wire                      sd_req_ready,
    input  wire                      sd_busy,
    input  wire                      sd_crc_error,
    input  wire                      sd_timeout_error,
    output cart_pkg::sd_cmd_t        sd_req,
    output logic                     sd_req_valid,
    output logic [`CART_DATA_W-1:0]  sdc_rdata,
    output logic                     sdc_hit,
    output logic                     sd_enabled
);

    import cart_pkg::*;

    logic                      win_sel;
    logic                      win_hit;
    logic                      wr_seen;
    logic                      wr_first;
    logic                      req_stall;
    logic                      cmd_accept;
    logic                      enable_q;
    logic [`CART_SECTOR_W-1:0] sector_q;
    sd_op_e                    cmd_op;

    //////////////////////////////////////////////////
    // window decode
    //////////////////////////////////////////////////

    assign win_sel = !cycle.sltsl_n && !cycle.merq_n && cycle.iorq_n && cycle.m1_n
                     && (cycle.addr >= `SDC_ENABLE_ADDR) && (cycle.addr <= `SDC_END_ADDR);
    assign win_hit = win_sel && enable_q;

    // the same write is seen on every rotation while wr_n stays low
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            wr_seen <= 1'b0;
        end else if (cycle.wr_n) begin
            wr_seen <= 1'b0;
        end else if (cycle_valid) begin
            wr_seen <= 1'b1;
        end
    end

    assign wr_first = cycle_valid && !cycle.wr_n && !wr_seen;

    // lowest set bit wins
    always_comb begin
        if (data_in[0]) begin
            cmd_op = SD_READ;
        end else if (data_in[1]) begin
            cmd_op = SD_WRITE;
        end else if (data_in[7]) begin
            cmd_op = SD_INIT;
        end else begin
            cmd_op = SD_NONE;
        end
    end

    assign req_stall  = sd_req_valid && !sd_req_ready;    // engine still holding us off
    assign cmd_accept = wr_first && win_hit && (cycle.addr == `SDC_CMD_ADDR)
                        && !req_stall && (cmd_op != SD_NONE);

    //////////////////////////////////////////////////
    // registers and request channel
    //////////////////////////////////////////////////

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            enable_q     <= 1'b0;
            sd_req_valid <= 1'b0;
        end else begin
            if (sd_req_valid && sd_req_ready) begin
                sd_req_valid <= 1'b0;
            end
            if (cmd_accept) begin
                sd_req_valid <= 1'b1;   // wins over a same-edge transfer
            end
            if (wr_first && win_sel && (cycle.addr == `SDC_ENABLE_ADDR)) begin
                enable_q <= data_in[0];
            end
        end
    end

    always_ff @(posedge clk108_w) begin
        if (wr_first && win_hit) begin
            case (cycle.addr)
                `SDC_SADDR_ADDR + 16'd0: sector_q[7:0]   <= data_in;
                `SDC_SADDR_ADDR + 16'd1: sector_q[15:8]  <= data_in;
                `SDC_SADDR_ADDR + 16'd2: sector_q[23:16] <= data_in;
                `SDC_SADDR_ADDR + 16'd3: sector_q[31:24] <= data_in;
                default: ;
            endcase
        end
        if (cmd_accept) begin
            sd_req.op     <= cmd_op;
            sd_req.sector <= sector_q;  // snapshot, later saddr writes don't move it
        end
    end

    // read mux, the responder registers it
    always_comb begin
        case (cycle.addr)
            `SDC_ENABLE_ADDR:        sdc_rdata = {7'b0, enable_q};
            `SDC_STATUS_ADDR:        sdc_rdata = {sd_busy, 5'b0, sd_timeout_error, sd_crc_error};
            `SDC_SADDR_ADDR + 16'd0: sdc_rdata = sector_q[7:0];
            `SDC_SADDR_ADDR + 16'd1: sdc_rdata = sector_q[15:8];
            `SDC_SADDR_ADDR + 16'd2: sdc_rdata = sector_q[23:16];
            `SDC_SADDR_ADDR + 16'd3: sdc_rdata = sector_q[31:24];
            default:                 sdc_rdata = `CART_IDLE_DATA;
        endcase
    end

    assign sdc_hit    = win_hit && !cycle.rd_n;
    assign sd_enabled = enable_q;

endmodule

`default_nettype wire
